//--- adc_eth_top.f
+incdir+.
gmii_pkg.sv
stream_pkg.sv
sample_fifo.sv
packet_sender.sv
gmii_tx_framer.sv
adc_eth_top.sv
adc_eth_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := adc_eth_tb
FILELIST   := adc_eth_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

SOURCES    := $(shell grep -v '^+' $(FILELIST)) adc_eth_defines.svh
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- adc_eth_tb.sv
`timescale 1ns/1ps
`include "adc_eth_defines.svh"

module adc_eth_tb;
	import stream_pkg::*;
	import gmii_pkg::*;

	// Longest frame plus gap and handshake slack
	localparam int FRAME_CYCLES    = 9 + 4 * `ADC_PKT_WORDS + `IFG_CYCLES + 8;
	// 12 frames of up to FRAME_CYCLES plus stimulus, about 3x margin
	localparam int WATCHDOG_CYCLES = 4000;
	localparam int BURST_SAMPLES   = `ADC_FIFO_DEPTH + 6; // Six past a full FIFO

	logic        GMII_GTX_CLK_int;
	logic        rst_n_i;
	logic        adc_valid_i;
	adc_sample_t adc_sample_i;
	logic        adc_overflow_o;
	logic        cfg_valid_i;
	cfg_word_t   cfg_word_i;
	logic        cfg_ready_o;
	gmii_tx_t    gmii_o;

	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          adc_level;   // Model of ADC FIFO occupancy
	int          frames_done;
	int          gap_cnt;     // Idle cycles since last frame
	logic        in_frame;
	logic [7:0]  frame_q[$];  // Bytes of the frame on the line
	logic [31:0] exp_adc_q[$];
	logic [31:0] exp_cfg_q[$];
	logic [7:0]  tag_log[$];  // Tag of every finished frame

	adc_eth_top i_dut (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.adc_valid_i      (adc_valid_i),
		.adc_sample_i     (adc_sample_i),
		.adc_overflow_o   (adc_overflow_o),
		.cfg_valid_i      (cfg_valid_i),
		.cfg_word_i       (cfg_word_i),
		.cfg_ready_o      (cfg_ready_o),
		.gmii_o           (gmii_o)
	);

	always #10 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: %s got 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// One sample per cycle, kept only if the modelled FIFO has room
	task automatic drive_adc(input adc_sample_t s);
		adc_valid_i  = 1'b1;
		adc_sample_i = s;
		if (adc_level < `ADC_FIFO_DEPTH)
		begin
			exp_adc_q.push_back({s.cha, s.chb}); // Channel A is the upper half
			adc_level++;
		end
		@(negedge GMII_GTX_CLK_int);
	endtask

	task automatic write_adc_samples(input int n);
		int k;
		for (k = 0; k < n; k++)
			drive_adc(adc_sample_t'(next_random()));
		adc_valid_i = 1'b0;
	endtask

	task automatic send_cfg(input cfg_word_t w);
		cfg_valid_i = 1'b1;
		cfg_word_i  = w;
		while (!cfg_ready_o)
			@(negedge GMII_GTX_CLK_int);
		@(negedge GMII_GTX_CLK_int);
		cfg_valid_i = 1'b0;
		exp_cfg_q.push_back(w);
	endtask

	task automatic wait_frames(input int n);
		while (frames_done < n)
			@(negedge GMII_GTX_CLK_int);
	endtask

	task automatic wait_frame_start();
		while (!gmii_o.tx_en)
			@(negedge GMII_GTX_CLK_int);
	endtask

	////////////////////////////////////////
	// Frame monitor
	////////////////////////////////////////

	task automatic check_frame();
		int          n_words;
		int          w;
		int          b;
		logic [31:0] exp_word;
		logic [7:0]  tag;
		frames_done++;
		if (frame_q.size() < 9)
		begin
			tag_log.push_back(8'h00);
			report_error($sformatf("frame of only %0d bytes", frame_q.size()));
			return;
		end
		for (b = 0; b < `PREAMBLE_LEN; b++)
			check_byte(frame_q[b], `PREAMBLE_BYTE, "preamble byte");
		check_byte(frame_q[7], `SFD_BYTE, "start delimiter");
		tag = frame_q[8];
		tag_log.push_back(tag);
		if (tag == `TAG_ADC)
			n_words = `ADC_PKT_WORDS;
		else if (tag == `TAG_CFG)
			n_words = `CFG_PKT_WORDS;
		else
		begin
			report_error($sformatf("frame with unknown tag 0x%02h", tag));
			return;
		end
		check_count(frame_q.size(), 9 + 4 * n_words, "frame length in bytes");
		if (frame_q.size() != 9 + 4 * n_words)
			return;
		for (w = 0; w < n_words; w++)
		begin
			if (tag == `TAG_ADC && exp_adc_q.size() > 0)
				exp_word = exp_adc_q.pop_front();
			else if (tag == `TAG_CFG && exp_cfg_q.size() > 0)
				exp_word = exp_cfg_q.pop_front();
			else
			begin
				report_error("frame carries more words than were written");
				return;
			end
			for (b = 0; b < 4; b++)
			begin
				check_byte(frame_q[9 + 4 * w + b], exp_word[31:24], "data byte");
				exp_word = exp_word << 8; // Most significant byte first
			end
		end
		if (tag == `TAG_ADC)
			adc_level -= `ADC_PKT_WORDS;
	endtask

	always @(posedge GMII_GTX_CLK_int)
	begin
		if (rst_n_i)
		begin
			if (gmii_o.tx_en)
			begin
				if (!in_frame)
				begin
					if (frames_done > 0)
					begin
						checks++;
						assert (gap_cnt >= `IFG_CYCLES)
						else
						begin
							errors++;
							$display("MISMATCH at %0t: gap of %0d cycles, expected at least %0d",
							         $time, gap_cnt, `IFG_CYCLES);
						end
					end
					in_frame = 1'b1;
					frame_q.delete();
				end
				frame_q.push_back(gmii_o.txd);
			end
			else
			begin
				if (in_frame)
				begin
					check_frame();
					in_frame = 1'b0;
					gap_cnt  = 0;
				end
				gap_cnt++;
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		int base;
		int i;
		GMII_GTX_CLK_int = 1'b0;
		rst_n_i          = 1'b0;
		adc_valid_i      = 1'b0;
		adc_sample_i     = '0;
		cfg_valid_i      = 1'b0;
		cfg_word_i       = '0;
		rng_state        = 32'd78606;
		errors           = 0;
		checks           = 0;
		adc_level        = 0;
		frames_done      = 0;
		gap_cnt          = 0;
		in_frame         = 1'b0;
		repeat (2) @(negedge GMII_GTX_CLK_int);
		rst_n_i = 1'b1;

		// Quiet line after reset
		repeat (20)
		begin
			check_flag(gmii_o.tx_en, 1'b0, "tx_en after reset");
			check_flag(adc_overflow_o, 1'b0, "adc_overflow_o after reset");
			check_flag(cfg_ready_o, 1'b1, "cfg_ready_o after reset");
			@(negedge GMII_GTX_CLK_int);
		end

		// One ADC packet, one frame
		write_adc_samples(`ADC_PKT_WORDS);
		wait_frames(1);

		// Config queued behind a busy framer goes out before the next ADC packet
		base = frames_done;
		write_adc_samples(`ADC_PKT_WORDS);
		wait_frame_start();
		write_adc_samples(`ADC_PKT_WORDS);
		for (i = 0; i < `CFG_PKT_WORDS; i++)
			send_cfg(cfg_word_t'(next_random()));
		wait_frames(base + 3);
		check_byte(tag_log[base], `TAG_ADC, "tag of first frame");
		check_byte(tag_log[base + 1], `TAG_CFG, "tag after both sources buffered");
		check_byte(tag_log[base + 2], `TAG_ADC, "tag of last frame");

		// Partial packet stays buffered
		base = frames_done;
		write_adc_samples(`ADC_PKT_WORDS - 6);
		repeat (FRAME_CYCLES)
		begin
			check_flag(gmii_o.tx_en, 1'b0, "tx_en with a partial ADC packet");
			@(negedge GMII_GTX_CLK_int);
		end
		write_adc_samples(6);
		wait_frames(base + 1);

		// Config frames hold the sender off while the ADC FIFO overruns
		base = frames_done;
		check_flag(adc_overflow_o, 1'b0, "adc_overflow_o before burst");
		for (i = 0; i < 3 * `CFG_PKT_WORDS; i++)
			send_cfg(cfg_word_t'(next_random()));
		wait_frame_start();
		write_adc_samples(BURST_SAMPLES);
		check_flag(adc_overflow_o, 1'b1, "adc_overflow_o after burst");
		wait_frames(base + 7);
		for (i = 0; i < 7; i++)
			check_byte(tag_log[base + i], (i < 3) ? `TAG_CFG : `TAG_ADC, "tag after overflow");
		check_flag(adc_overflow_o, 1'b1, "adc_overflow_o held");

		repeat (FRAME_CYCLES) @(negedge GMII_GTX_CLK_int);
		check_count(frames_done, 12, "frames seen");
		check_count(exp_adc_q.size(), 0, "ADC words never sent");
		check_count(exp_cfg_q.size(), 0, "config words never sent");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge GMII_GTX_CLK_int);
		errors++;
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- adc_eth_top.sv
`timescale 1ns/1ps
`include "adc_eth_defines.svh"

module adc_eth_top (
	input  logic                    GMII_GTX_CLK_int,
	input  logic                    rst_n_i,

	input  logic                    adc_valid_i,
	input  stream_pkg::adc_sample_t adc_sample_i,
	output logic                    adc_overflow_o,

	input  logic                    cfg_valid_i,
	input  stream_pkg::cfg_word_t   cfg_word_i,
	output logic                    cfg_ready_o,

	output gmii_pkg::gmii_tx_t      gmii_o
);
	import stream_pkg::*;

	adc_sample_t adc_rd_data;
	logic        adc_rd_valid;
	logic        adc_rd_ready;
	logic        adc_pkt_ready;

	cfg_word_t   cfg_rd_data;
	logic        cfg_rd_valid;
	logic        cfg_rd_ready;
	logic        cfg_pkt_ready;

	pkt_word_t   tx_word;
	logic        tx_valid;
	logic        tx_ready;

	////////////////////////////////////////
	// Input buffers
	////////////////////////////////////////

	// Converter never stalls, so no ready back to it
	sample_fifo #(
		.payload_t (adc_sample_t),
		.DEPTH     (`ADC_FIFO_DEPTH),
		.PKT_WORDS (`ADC_PKT_WORDS)
	) i_adc_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.wr_valid_i       (adc_valid_i),
		.wr_data_i        (adc_sample_i),
		.wr_ready_o       (),
		.rd_valid_o       (adc_rd_valid),
		.rd_data_o        (adc_rd_data),
		.rd_ready_i       (adc_rd_ready),
		.pkt_ready_o      (adc_pkt_ready),
		.overflow_o       (adc_overflow_o)
	);

	sample_fifo #(
		.payload_t (cfg_word_t),
		.DEPTH     (`CFG_FIFO_DEPTH),
		.PKT_WORDS (`CFG_PKT_WORDS)
	) i_cfg_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.wr_valid_i       (cfg_valid_i),
		.wr_data_i        (cfg_word_i),
		.wr_ready_o       (cfg_ready_o),
		.rd_valid_o       (cfg_rd_valid),
		.rd_data_o        (cfg_rd_data),
		.rd_ready_i       (cfg_rd_ready),
		.pkt_ready_o      (cfg_pkt_ready),
		.overflow_o       ()
	);

	////////////////////////////////////////
	// Packetizer and line side
	////////////////////////////////////////

	packet_sender i_sender (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.cfg_valid_i      (cfg_rd_valid),
		.cfg_data_i       (cfg_rd_data),
		.cfg_pkt_ready_i  (cfg_pkt_ready),
		.cfg_ready_o      (cfg_rd_ready),
		.adc_valid_i      (adc_rd_valid),
		.adc_data_i       (adc_rd_data),
		.adc_pkt_ready_i  (adc_pkt_ready),
		.adc_ready_o      (adc_rd_ready),
		.out_valid_o      (tx_valid),
		.out_word_o       (tx_word),
		.out_ready_i      (tx_ready)
	);

	gmii_tx_framer i_framer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.in_valid_i       (tx_valid),
		.in_word_i        (tx_word),
		.in_ready_o       (tx_ready),
		.gmii_o           (gmii_o)
	);

endmodule

//--- gmii_tx_framer.sv
`timescale 1ns/1ps
`include "adc_eth_defines.svh"

module gmii_tx_framer (
	input  logic                  GMII_GTX_CLK_int,
	input  logic                  rst_n_i,
	input  logic                  in_valid_i,
	input  stream_pkg::pkt_word_t in_word_i,
	output logic                  in_ready_o,
	output gmii_pkg::gmii_tx_t    gmii_o
);
	import stream_pkg::*;
	import gmii_pkg::*;

	// Counter covers preamble, byte lanes and gap
	localparam int CNT_W = $clog2((`IFG_CYCLES > `PREAMBLE_LEN) ? `IFG_CYCLES : `PREAMBLE_LEN);

	framer_state_t      state_q;
	logic [CNT_W-1:0]   cnt_q;
	logic [`DATA_W-1:0] shift_q;
	logic               src_q;
	logic               eop_q; // Word in shift_q ends the packet
	logic               word_end;
	logic               take;
	gmii_tx_t           tx_next;

	assign word_end   = (state_q == fr_data) && (cnt_q == CNT_W'(3));
	assign in_ready_o = (state_q == fr_idle) || (word_end && !eop_q);
	assign take       = in_valid_i && in_ready_o;

	////////////////////////////////////////
	// Byte select
	////////////////////////////////////////

	always_comb
	begin
		tx_next = '0;
		case (state_q)
			fr_preamble:
			begin
				tx_next.tx_en = 1'b1;
				tx_next.txd   = `PREAMBLE_BYTE;
			end
			fr_sfd:
			begin
				tx_next.tx_en = 1'b1;
				tx_next.txd   = `SFD_BYTE;
			end
			fr_tag:
			begin
				tx_next.tx_en = 1'b1;
				tx_next.txd   = (src_q == SRC_ADC) ? `TAG_ADC : `TAG_CFG;
			end
			fr_data:
			begin
				tx_next.tx_en = 1'b1;
				tx_next.txd   = shift_q[`DATA_W-1 -: 8]; // MSB first
			end
			default: tx_next = '0;
		endcase
	end

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= fr_idle;
			cnt_q   <= '0;
			src_q   <= SRC_CFG;
			eop_q   <= 1'b0;
		end
		else
		begin
			case (state_q)
				fr_idle:
					if (take && in_word_i.flags.sop) // Stray words are dropped
					begin
						state_q <= fr_preamble;
						cnt_q   <= '0;
						src_q   <= in_word_i.flags.src;
						eop_q   <= in_word_i.flags.eop;
					end
				fr_preamble:
					if (cnt_q == CNT_W'(`PREAMBLE_LEN - 1))
					begin
						state_q <= fr_sfd;
						cnt_q   <= '0;
					end
					else
						cnt_q <= cnt_q + 1'b1;
				fr_sfd:
					state_q <= fr_tag;
				fr_tag:
					state_q <= fr_data;
				fr_data:
					if (!word_end)
						cnt_q <= cnt_q + 1'b1;
					else if (take)
					begin
						cnt_q <= '0;
						eop_q <= in_word_i.flags.eop;
					end
					else
					begin
						// End of packet, or source ran dry
						state_q <= fr_gap;
						cnt_q   <= '0;
					end
				fr_gap:
					if (cnt_q == CNT_W'(`IFG_CYCLES - 1))
					begin
						state_q <= fr_idle;
						cnt_q   <= '0;
					end
					else
						cnt_q <= cnt_q + 1'b1;
				default:
					state_q <= fr_idle;
			endcase
		end
	end

	// Word shifter, next word lands as the last byte goes out
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (take)
			shift_q <= in_word_i.data;
		else if (state_q == fr_data)
			shift_q <= shift_q << 8;
	end

	// Registered PHY outputs
	always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
	begin
		if (!rst_n_i)
			gmii_o <= '0;
		else
			gmii_o <= tx_next;
	end

endmodule

//--- packet_sender.sv
`timescale 1ns/1ps
`include "adc_eth_defines.svh"

module packet_sender (
	input  logic                    GMII_GTX_CLK_int,
	input  logic                    rst_n_i,

	// Configuration source, wins arbitration
	input  logic                    cfg_valid_i,
	input  stream_pkg::cfg_word_t   cfg_data_i,
	input  logic                    cfg_pkt_ready_i,
	output logic                    cfg_ready_o,

	// ADC source
	input  logic                    adc_valid_i,
	input  stream_pkg::adc_sample_t adc_data_i,
	input  logic                    adc_pkt_ready_i,
	output logic                    adc_ready_o,

	output logic                    out_valid_o,
	output stream_pkg::pkt_word_t   out_word_o,
	input  logic                    out_ready_i
);
	import stream_pkg::*;

	localparam int CNT_W = $clog2(`ADC_PKT_WORDS) + 1;

	logic               busy_q;
	logic               src_q;
	logic [CNT_W-1:0]   cnt_q; // Index of next word to load
	logic               out_valid_q;
	pkt_word_t          out_word_q;

	logic               ld_en;
	logic               ld_first;
	logic               ld_src;
	logic [CNT_W-1:0]   ld_idx;
	logic [CNT_W-1:0]   ld_last_idx;
	logic [`DATA_W-1:0] ld_data;
	logic               take;

	assign take = out_valid_q && out_ready_i;

	////////////////////////////////////////
	// Arbitration and load decision
	////////////////////////////////////////

	always_comb
	begin
		ld_en    = 1'b0;
		ld_first = 1'b0;
		ld_src   = src_q;
		if (!busy_q)
		begin
			if (cfg_pkt_ready_i && cfg_valid_i)
			begin
				ld_en    = 1'b1;
				ld_first = 1'b1;
				ld_src   = SRC_CFG;
			end
			else if (adc_pkt_ready_i && adc_valid_i)
			begin
				ld_en    = 1'b1;
				ld_first = 1'b1;
				ld_src   = SRC_ADC;
			end
		end
		else if (!out_valid_q || (out_ready_i && !out_word_q.flags.eop))
			ld_en = (src_q == SRC_ADC) ? adc_valid_i : cfg_valid_i;
	end

	assign ld_idx      = ld_first ? '0 : cnt_q;
	assign ld_last_idx = (ld_src == SRC_ADC) ? CNT_W'(`ADC_PKT_WORDS - 1)
	                                         : CNT_W'(`CFG_PKT_WORDS - 1);
	assign ld_data     = (ld_src == SRC_ADC) ? {adc_data_i.cha, adc_data_i.chb} : cfg_data_i;

	// Pop whichever FIFO feeds the output register
	assign cfg_ready_o = ld_en && (ld_src == SRC_CFG);
	assign adc_ready_o = ld_en && (ld_src == SRC_ADC);

	////////////////////////////////////////
	// Control state
	////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			busy_q      <= 1'b0;
			src_q       <= SRC_CFG;
			cnt_q       <= '0;
			out_valid_q <= 1'b0;
		end
		else if (ld_en)
		begin
			busy_q      <= 1'b1;
			src_q       <= ld_src;
			cnt_q       <= ld_idx + 1'b1;
			out_valid_q <= 1'b1;
		end
		else if (take)
		begin
			out_valid_q <= 1'b0;
			if (out_word_q.flags.eop)
				busy_q <= 1'b0; // Packet done, back to arbitration
		end
	end

	// Output word, held until taken
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (ld_en)
		begin
			out_word_q.flags.sop <= (ld_idx == '0);
			out_word_q.flags.eop <= (ld_idx == ld_last_idx);
			out_word_q.flags.src <= ld_src;
			out_word_q.data      <= ld_data;
		end
	end

	assign out_valid_o = out_valid_q;
	assign out_word_o  = out_word_q;

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps
`include "adc_eth_defines.svh"

module sample_fifo #(
	parameter type payload_t = logic [`DATA_W-1:0],
	parameter int  DEPTH     = 64,
	parameter int  PKT_WORDS = 16
) (
	input  logic     GMII_GTX_CLK_int,
	input  logic     rst_n_i,

	input  logic     wr_valid_i,
	input  payload_t wr_data_i,
	output logic     wr_ready_o,

	output logic     rd_valid_o,
	output payload_t rd_data_o,
	input  logic     rd_ready_i,

	output logic     pkt_ready_o,
	output logic     overflow_o
);

	localparam int AW = $clog2(DEPTH);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0]   level_q;
	logic          full;
	logic          wr_en;
	logic          rd_en;

	assign full       = (level_q == (AW+1)'(DEPTH));
	assign wr_ready_o = !full;
	assign rd_valid_o = (level_q != '0);
	assign rd_data_o  = mem[rd_ptr_q]; // Show-ahead read

	assign wr_en = wr_valid_i && !full;
	assign rd_en = rd_valid_o && rd_ready_i;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (wr_en)
			mem[wr_ptr_q] <= wr_data_i;
	end

	////////////////////////////////////////
	// Pointers and level
	////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			level_q     <= '0;
			pkt_ready_o <= 1'b0;
			overflow_o  <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

			case ({wr_en, rd_en})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: level_q <= level_q;
			endcase

			// Whole packet buffered, lags the level by a cycle
			pkt_ready_o <= (level_q >= (AW+1)'(PKT_WORDS));

			if (wr_valid_i && full)
				overflow_o <= 1'b1; // Sticky until reset
		end
	end

endmodule

//--- stream_pkg.sv
package stream_pkg;
`include "adc_eth_defines.svh"

	////////////////////////////////////////
	// Payloads
	////////////////////////////////////////

	// One converter sample, channel A on top
	typedef struct packed {
		logic [`SAMPLE_W-1:0] cha;
		logic [`SAMPLE_W-1:0] chb;
	} adc_sample_t;

	typedef logic [`DATA_W-1:0] cfg_word_t; // Raw config word

	////////////////////////////////////////
	// Packet words
	////////////////////////////////////////

	// Source encoding of the src flag
	localparam logic SRC_CFG = 1'b0;
	localparam logic SRC_ADC = 1'b1;

	typedef struct packed {
		logic sop; // First word of packet
		logic eop; // Last word of packet
		logic src; // Which FIFO it came from
	} pkt_flags_t;

	typedef struct packed {
		pkt_flags_t         flags;
		logic [`DATA_W-1:0] data;
	} pkt_word_t;

endpackage

//--- gmii_pkg.sv
package gmii_pkg;

	// Transmit side of the PHY interface
	typedef struct packed {
		logic       tx_en;
		logic [7:0] txd;
	} gmii_tx_t;

	// Framer sequence, in transmit order
	typedef enum logic [2:0] {
		fr_idle,
		fr_preamble,
		fr_sfd,
		fr_tag,
		fr_data,
		fr_gap
	} framer_state_t;

endpackage

//--- adc_eth_defines.svh
`ifndef ADC_DEFINES_SVH
`define ADC_DEFINES_SVH

// Stream widths
`define DATA_W         32
`define SAMPLE_W       16

// FIFO depths in words
`define ADC_FIFO_DEPTH 64
`define CFG_FIFO_DEPTH 16

// Words per packet
`define ADC_PKT_WORDS  16
`define CFG_PKT_WORDS  4

// Frame preamble
`define PREAMBLE_BYTE  8'h55
`define PREAMBLE_LEN   7

// Start of frame delimiter
`define SFD_BYTE       8'hD5

// Source tags, sent right after the delimiter
`define TAG_CFG        8'h01
`define TAG_ADC        8'h02

// Idle cycles between frames
`define IFG_CYCLES     12

`endif
